// ==== include/axi_trace_consts.svh ====
`ifndef AXI_TRACE_CONSTS_SVH
`define AXI_TRACE_CONSTS_SVH

// AXI field widths seen by the tracer
`define AXI_ID_W 4
`define AXI_ADDR_W 32
`define AXI_LEN_W 8
`define AXI_DATA_W 64

// width of the trace stream payload, wide enough for the largest channel
`define TRACE_DATA_W 128

// AR, AW, R and B
`define TRACE_CHANNELS 4

`endif

// ==== hdl/axi_chan_pkg.sv ====
`include "axi_trace_consts.svh"

package axi_chan_pkg;

  // shared by AR and AW, id ends up in the top bits once packed
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } addr_chan_t;

  // read data beat as returned by the subordinate
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } rdata_chan_t;

  // write response
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [1:0]           resp;
  } bresp_chan_t;

endpackage

// ==== hdl/trace_pkg.sv ====
`include "axi_trace_consts.svh"

package trace_pkg;

  // the tag doubles as arbiter index and as the stream tdest value
  typedef enum logic [1:0] {
    CH_AR = 2'd0,
    CH_AW = 2'd1,
    CH_R  = 2'd2,
    CH_B  = 2'd3
  } chan_tag_e;

  // one captured handshake, data holds the payload zero-extended from bit 0
  typedef struct packed {
    chan_tag_e                tag;
    logic                     last;
    logic [`TRACE_DATA_W-1:0] data;
  } trace_beat_t;

endpackage

// ==== hdl/channel_tap.sv ====
`timescale 1ns/100ps

module channel_tap #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   enable,
  input  payload_t               src_payload,
  input  logic                   src_valid,
  input  logic                   sink_ready,
  input  logic                   is_last,
  input  trace_pkg::chan_tag_e   tag,
  input  logic                   grant,
  output payload_t               sink_payload,
  output logic                   sink_valid,
  output logic                   src_ready,
  output trace_pkg::trace_beat_t beat,
  output logic                   beat_valid
);

  localparam int PW = $bits(payload_t);

  trace_pkg::trace_beat_t beat_d;
  logic                   capture;

  // the payload itself is never touched
  assign sink_payload = src_payload;

  // while a captured beat waits for its grant the channel is frozen on
  // both sides, so the next handshake cannot overwrite it
  assign sink_valid = src_valid & ~beat_valid;
  assign src_ready  = sink_ready & ~beat_valid;

  // a disabled tap still forwards traffic but never captures
  assign capture = sink_valid & sink_ready & enable;

  always_comb begin
    beat_d          = '0;
    beat_d.tag      = tag;
    beat_d.last     = is_last;
    beat_d.data[PW-1:0] = src_payload;
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      beat_valid <= 1'b0;
    end else if (grant) begin
      beat_valid <= 1'b0;
    end else if (capture) begin
      beat_valid <= 1'b1;
    end
  end

  // capture and grant never coincide because capture needs an empty tap
  always_ff @(posedge clk) begin
    if (capture) begin
      beat <= beat_d;
    end
  end

endmodule

// ==== hdl/trace_arbiter.sv ====
`timescale 1ns/100ps
`include "axi_trace_consts.svh"

module trace_arbiter (
  input  logic                              clk,
  input  logic                              resetn,
  input  trace_pkg::trace_beat_t            beats [`TRACE_CHANNELS],
  input  logic [`TRACE_CHANNELS-1:0]        beat_valid,
  input  logic                              stage_free,
  output logic [`TRACE_CHANNELS-1:0]        grant,
  output trace_pkg::trace_beat_t            out_beat,
  output logic                              out_load
);

  localparam int IDX_W = $clog2(`TRACE_CHANNELS);

  // channel granted most recently, the search starts one past it
  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] sel;
  logic             found;
  // set while an R burst is being streamed and its last beat is still ahead
  logic             r_lock;

  always_comb begin : pick
    logic [IDX_W-1:0] idx;
    sel   = ptr;
    found = 1'b0;
    for (int i = 1; i <= `TRACE_CHANNELS; i++) begin
      idx = IDX_W'((int'(ptr) + i) % `TRACE_CHANNELS);
      // during a locked burst only the R tap may win
      if (!found && beat_valid[idx] && (!r_lock || idx == trace_pkg::CH_R)) begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  // the output stage must be able to take the beat in this very cycle
  assign out_load = found & stage_free;
  assign out_beat = beats[sel];

  always_comb begin
    grant = '0;
    if (out_load) begin
      grant[sel] = 1'b1;
    end
  end

  // pointer starts on CH_B so that CH_AR is looked at first
  always_ff @(posedge clk) begin
    if (resetn) begin
      ptr    <= trace_pkg::CH_B;
      r_lock <= 1'b0;
    end else if (out_load) begin
      ptr <= sel;
      if (sel == trace_pkg::CH_R) begin
        r_lock <= ~out_beat.last;
      end
    end
  end

endmodule

// ==== hdl/trace_output_stage.sv ====
`timescale 1ns/100ps
`include "axi_trace_consts.svh"

module trace_output_stage (
  input  logic                                   clk,
  input  logic                                   resetn,
  input  trace_pkg::trace_beat_t                 in_beat,
  input  logic                                   load,
  input  logic                                   stream_tready,
  output logic [`TRACE_DATA_W-1:0]               stream_tdata,
  output logic [$bits(trace_pkg::chan_tag_e)-1:0] stream_tdest,
  output logic                                   stream_tlast,
  output logic                                   stream_tvalid,
  output logic                                   stage_free
);

  trace_pkg::trace_beat_t beat_r;

  // the register drains this cycle if it is empty or being accepted
  assign stage_free = ~stream_tvalid | stream_tready;

  always_ff @(posedge clk) begin
    if (resetn) begin
      stream_tvalid <= 1'b0;
    end else if (stage_free) begin
      stream_tvalid <= load;
    end
  end

  // loads only arrive while the stage is free, so a stalled beat holds
  always_ff @(posedge clk) begin
    if (load) begin
      beat_r <= in_beat;
    end
  end

  assign stream_tdata = beat_r.data;
  assign stream_tdest = beat_r.tag;
  assign stream_tlast = beat_r.last;

endmodule

// ==== hdl/axi_trace_top.sv ====
`timescale 1ns/100ps
`include "axi_trace_consts.svh"

module axi_trace_top (
  input  logic                                    clk,
  input  logic                                    resetn,
  input  logic [`TRACE_CHANNELS-1:0]              channel_enable,
  // manager side
  input  axi_chan_pkg::addr_chan_t                m_ar,
  input  logic                                    m_ar_valid,
  output logic                                    m_ar_ready,
  input  axi_chan_pkg::addr_chan_t                m_aw,
  input  logic                                    m_aw_valid,
  output logic                                    m_aw_ready,
  output axi_chan_pkg::rdata_chan_t               m_r,
  output logic                                    m_r_valid,
  input  logic                                    m_r_ready,
  output axi_chan_pkg::bresp_chan_t               m_b,
  output logic                                    m_b_valid,
  input  logic                                    m_b_ready,
  // subordinate side
  output axi_chan_pkg::addr_chan_t                s_ar,
  output logic                                    s_ar_valid,
  input  logic                                    s_ar_ready,
  output axi_chan_pkg::addr_chan_t                s_aw,
  output logic                                    s_aw_valid,
  input  logic                                    s_aw_ready,
  input  axi_chan_pkg::rdata_chan_t               s_r,
  input  logic                                    s_r_valid,
  output logic                                    s_r_ready,
  input  axi_chan_pkg::bresp_chan_t               s_b,
  input  logic                                    s_b_valid,
  output logic                                    s_b_ready,
  // trace stream
  output logic [`TRACE_DATA_W-1:0]                stream_tdata,
  output logic [$bits(trace_pkg::chan_tag_e)-1:0] stream_tdest,
  output logic                                    stream_tlast,
  output logic                                    stream_tvalid,
  input  logic                                    stream_tready
);

  trace_pkg::trace_beat_t           beats [`TRACE_CHANNELS];
  logic [`TRACE_CHANNELS-1:0]       beat_valid;
  logic [`TRACE_CHANNELS-1:0]       grant;
  trace_pkg::trace_beat_t           out_beat;
  logic                             out_load;
  logic                             stage_free;

  // address channels flow from manager to subordinate
  channel_tap #(.payload_t(axi_chan_pkg::addr_chan_t)) tap_ar (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[trace_pkg::CH_AR]),
    .src_payload  (m_ar),
    .src_valid    (m_ar_valid),
    .sink_ready   (s_ar_ready),
    .is_last      (1'b1),
    .tag          (trace_pkg::CH_AR),
    .grant        (grant[trace_pkg::CH_AR]),
    .sink_payload (s_ar),
    .sink_valid   (s_ar_valid),
    .src_ready    (m_ar_ready),
    .beat         (beats[trace_pkg::CH_AR]),
    .beat_valid   (beat_valid[trace_pkg::CH_AR])
  );

  channel_tap #(.payload_t(axi_chan_pkg::addr_chan_t)) tap_aw (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[trace_pkg::CH_AW]),
    .src_payload  (m_aw),
    .src_valid    (m_aw_valid),
    .sink_ready   (s_aw_ready),
    .is_last      (1'b1),
    .tag          (trace_pkg::CH_AW),
    .grant        (grant[trace_pkg::CH_AW]),
    .sink_payload (s_aw),
    .sink_valid   (s_aw_valid),
    .src_ready    (m_aw_ready),
    .beat         (beats[trace_pkg::CH_AW]),
    .beat_valid   (beat_valid[trace_pkg::CH_AW])
  );

  // response channels flow back from subordinate to manager
  channel_tap #(.payload_t(axi_chan_pkg::rdata_chan_t)) tap_r (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[trace_pkg::CH_R]),
    .src_payload  (s_r),
    .src_valid    (s_r_valid),
    .sink_ready   (m_r_ready),
    .is_last      (s_r.last),
    .tag          (trace_pkg::CH_R),
    .grant        (grant[trace_pkg::CH_R]),
    .sink_payload (m_r),
    .sink_valid   (m_r_valid),
    .src_ready    (s_r_ready),
    .beat         (beats[trace_pkg::CH_R]),
    .beat_valid   (beat_valid[trace_pkg::CH_R])
  );

  channel_tap #(.payload_t(axi_chan_pkg::bresp_chan_t)) tap_b (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (channel_enable[trace_pkg::CH_B]),
    .src_payload  (s_b),
    .src_valid    (s_b_valid),
    .sink_ready   (m_b_ready),
    .is_last      (1'b1),
    .tag          (trace_pkg::CH_B),
    .grant        (grant[trace_pkg::CH_B]),
    .sink_payload (m_b),
    .sink_valid   (m_b_valid),
    .src_ready    (s_b_ready),
    .beat         (beats[trace_pkg::CH_B]),
    .beat_valid   (beat_valid[trace_pkg::CH_B])
  );

  trace_arbiter u_arbiter (
    .clk        (clk),
    .resetn     (resetn),
    .beats      (beats),
    .beat_valid (beat_valid),
    .stage_free (stage_free),
    .grant      (grant),
    .out_beat   (out_beat),
    .out_load   (out_load)
  );

  trace_output_stage u_output_stage (
    .clk           (clk),
    .resetn        (resetn),
    .in_beat       (out_beat),
    .load          (out_load),
    .stream_tready (stream_tready),
    .stream_tdata  (stream_tdata),
    .stream_tdest  (stream_tdest),
    .stream_tlast  (stream_tlast),
    .stream_tvalid (stream_tvalid),
    .stage_free    (stage_free)
  );

endmodule

// ==== bench/axi_trace_props.sv ====
`timescale 1ns/100ps
`include "axi_trace_consts.svh"

module axi_trace_props (
  input logic                       clk,
  input logic                       resetn,
  input logic [`TRACE_DATA_W-1:0]   stream_tdata,
  input logic [1:0]                 stream_tdest,
  input logic                       stream_tlast,
  input logic                       stream_tvalid,
  input logic                       stream_tready,
  input logic [`TRACE_CHANNELS-1:0] grant,
  input logic [`TRACE_CHANNELS-1:0] beat_valid,
  input logic                       s_ar_valid,
  input logic                       s_aw_valid,
  input logic                       m_r_valid,
  input logic                       m_b_valid
);

  logic [`TRACE_CHANNELS-1:0] sink_valid;

  // outgoing valids in tag order AR, AW, R, B
  assign sink_valid = {m_b_valid, m_r_valid, s_aw_valid, s_ar_valid};

  stream_held: assert property (@(posedge clk) disable iff (resetn)
    stream_tvalid && !stream_tready |=>
      stream_tvalid && $stable({stream_tdata, stream_tdest, stream_tlast}))
    else $error("stream beat changed while the consumer stalled");

  // a granted tap reaches the stream one cycle later under its own tag
  grant_onehot: assert property (@(posedge clk) disable iff (resetn)
    grant != '0 |=>
      stream_tvalid && ((`TRACE_CHANNELS'(1) << stream_tdest) == $past(grant)))
    else $error("a grant was not one-hot or its beat did not reach the stream");

  // a tap that holds an ungranted capture keeps its channel closed after the edge
  full_stalls: assert property (@(posedge clk) disable iff (resetn)
    (beat_valid & ~grant) != '0 |=>
      (sink_valid & $past(beat_valid & ~grant)) == '0)
    else $error("a full tap passed a valid on to its sink");

endmodule

bind axi_trace_top axi_trace_props props_i (.*);

// ==== bench/axi_trace_tb.sv ====
`timescale 1ns/100ps
`include "axi_trace_consts.svh"

module axi_trace_tb;

  localparam int N_CH      = `TRACE_CHANNELS;
  localparam int NUM_TESTS = 7;
  localparam int W         = `TRACE_DATA_W;
  localparam logic [1:0] AR = trace_pkg::CH_AR;
  localparam logic [1:0] AW = trace_pkg::CH_AW;
  localparam logic [1:0] R  = trace_pkg::CH_R;
  localparam logic [1:0] B  = trace_pkg::CH_B;

  // expected tags sit two bits each with the first beat in the low bits
  typedef struct packed {
    logic [N_CH-1:0] enable;
    logic [N_CH-1:0] fire;
    logic [3:0]      r_len;
    logic            hold;
    logic [3:0]      n_tags;
    logic [15:0]     tags;
  } test_t;

  logic clk = 1'b0;
  logic resetn = 1'b1;
  logic [N_CH-1:0] channel_enable = '1;
  axi_chan_pkg::addr_chan_t  m_ar = '0;
  axi_chan_pkg::addr_chan_t  m_aw = '0;
  axi_chan_pkg::rdata_chan_t s_r = '0;
  axi_chan_pkg::bresp_chan_t s_b = '0;
  axi_chan_pkg::addr_chan_t  s_ar;
  axi_chan_pkg::addr_chan_t  s_aw;
  axi_chan_pkg::rdata_chan_t m_r;
  axi_chan_pkg::bresp_chan_t m_b;
  logic m_ar_valid = 1'b0;
  logic m_aw_valid = 1'b0;
  logic s_r_valid = 1'b0;
  logic s_b_valid = 1'b0;
  logic s_ar_ready = 1'b1;
  logic s_aw_ready = 1'b1;
  logic m_r_ready = 1'b1;
  logic m_b_ready = 1'b1;
  logic m_ar_ready;
  logic m_aw_ready;
  logic s_r_ready;
  logic s_b_ready;
  logic s_ar_valid;
  logic s_aw_valid;
  logic m_r_valid;
  logic m_b_valid;
  logic [W-1:0] stream_tdata;
  logic [1:0]   stream_tdest;
  logic stream_tlast;
  logic stream_tvalid;
  logic stream_tready = 1'b0;

  test_t tests [NUM_TESTS];
  string names [NUM_TESTS];
  test_t cur;
  int left [N_CH];
  logic [N_CH-1:0] hs = '0;
  // {tlast, tdata} expected per channel in handshake order
  logic [W:0] exp_mem [N_CH][16];
  int wr_idx [N_CH];
  int rd_idx [N_CH];
  int got;
  int errors = 0;
  int test_errors = 0;
  int tests_failed = 0;

  axi_trace_top dut_i (.*);

  always #5 clk = ~clk;

  function automatic axi_chan_pkg::rdata_chan_t rand_rdata(input logic last);
    axi_chan_pkg::rdata_chan_t r;
    r      = $bits(axi_chan_pkg::rdata_chan_t)'({$urandom, $urandom, $urandom});
    r.last = last;
    return r;
  endfunction

  // stream words are the payload fields in declaration order and zero-extended
  function automatic logic [W-1:0] addr_word(input axi_chan_pkg::addr_chan_t a);
    return W'({a.id, a.addr, a.len, a.size, a.burst});
  endfunction

  function automatic int pending();
    return left[AR] + left[AW] + left[R] + left[B];
  endfunction

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic expect_beat(input logic [1:0] ch, input logic last, input logic [W-1:0] word);
    exp_mem[ch][wr_idx[ch]] = {last, word};
    wr_idx[ch]++;
  endtask

  task automatic check_beat();
    logic [1:0] tag;
    logic [W:0] want;
    if (got >= cur.n_tags) begin
      report_error($sformatf("extra stream beat with tdest %0d", stream_tdest));
    end else begin
      tag = cur.tags[2*got +: 2];
      if (stream_tdest !== tag) begin
        report_error($sformatf("beat %0d has tdest %0d, expected %0d", got, stream_tdest, tag));
      end else if (rd_idx[tag] == wr_idx[tag]) begin
        report_error($sformatf("beat %0d on channel %0d had no handshake", got, tag));
      end else begin
        want = exp_mem[tag][rd_idx[tag]];
        rd_idx[tag]++;
        if (stream_tdata !== want[W-1:0] || stream_tlast !== want[W])
          report_error($sformatf("beat %0d is %h/%b, expected %h/%b", got,
                                 stream_tdata, stream_tlast, want[W-1:0], want[W]));
      end
    end
    got++;
  endtask

  // runs just before a rising edge when every signal has settled
  task automatic sample_edge();
    hs = {s_b_valid & s_b_ready, s_r_valid & s_r_ready,
          m_aw_valid & m_aw_ready, m_ar_valid & m_ar_ready};
    if (hs[AR] && (!s_ar_valid || s_ar !== m_ar))
      report_error("AR payload changed on its way through");
    if (hs[AW] && (!s_aw_valid || s_aw !== m_aw))
      report_error("AW payload changed on its way through");
    if (hs[R] && (!m_r_valid || m_r !== s_r))
      report_error("R payload changed on its way through");
    if (hs[B] && (!m_b_valid || m_b !== s_b))
      report_error("B payload changed on its way through");
    if (hs[AR] && cur.enable[AR])
      expect_beat(AR, 1'b1, addr_word(m_ar));
    if (hs[AW] && cur.enable[AW])
      expect_beat(AW, 1'b1, addr_word(m_aw));
    if (hs[R] && cur.enable[R])
      expect_beat(R, s_r.last, W'({s_r.id, s_r.data, s_r.resp, s_r.last}));
    if (hs[B] && cur.enable[B])
      expect_beat(B, 1'b1, W'({s_b.id, s_b.resp}));
    if (stream_tvalid && stream_tready)
      check_beat();
  endtask

  // runs on a falling edge and retires the handshakes seen at the last edge
  task automatic drive_inputs(input logic hold_tready);
    left[AR] -= hs[AR];
    left[AW] -= hs[AW];
    left[R]  -= hs[R];
    left[B]  -= hs[B];
    if (hs[AR])
      m_ar = $bits(axi_chan_pkg::addr_chan_t)'({$urandom, $urandom});
    if (hs[AW])
      m_aw = $bits(axi_chan_pkg::addr_chan_t)'({$urandom, $urandom});
    if (hs[R])
      s_r = rand_rdata(left[R] == 1);
    if (hs[B])
      s_b = $bits(axi_chan_pkg::bresp_chan_t)'($urandom);
    hs = '0;
    m_ar_valid    = left[AR] > 0;
    m_aw_valid    = left[AW] > 0;
    s_r_valid     = left[R] > 0;
    s_b_valid     = left[B] > 0;
    stream_tready = hold_tready ? 1'b0 : (($urandom % 4) != 0);
  endtask

  task automatic run_test(input int t);
    int cyc;
    cur            = tests[t];
    test_errors    = 0;
    got            = 0;
    cyc            = 0;
    hs             = '0;
    channel_enable = cur.enable;
    for (int c = 0; c < N_CH; c++) begin
      left[c]   = cur.fire[c] ? ((c == R) ? int'(cur.r_len) : 1) : 0;
      wr_idx[c] = 0;
      rd_idx[c] = 0;
    end
    m_ar = $bits(axi_chan_pkg::addr_chan_t)'({$urandom, $urandom});
    m_aw = $bits(axi_chan_pkg::addr_chan_t)'({$urandom, $urandom});
    s_r  = rand_rdata(left[R] == 1);
    s_b  = $bits(axi_chan_pkg::bresp_chan_t)'($urandom);
    while (got < cur.n_tags || pending() > 0) begin
      drive_inputs(cur.hold && (cyc < 6 || pending() > 0));
      #4;
      sample_edge();
      @(negedge clk);
      cyc++;
    end
    // a duplicated beat would surface here
    repeat (5) begin
      drive_inputs(1'b0);
      #4;
      sample_edge();
      @(negedge clk);
    end
    for (int c = 0; c < N_CH; c++) begin
      if (rd_idx[c] != wr_idx[c])
        report_error($sformatf("%0d beats of channel %0d never reached the stream",
                               wr_idx[c] - rd_idx[c], c));
    end
    if (test_errors != 0)
      tests_failed++;
    $display("%s: %0d errors", names[t], test_errors);
  endtask

  initial begin
    void'($urandom(32'h9a20_b907));
    tests[0] = '{4'hf, 4'b1001, 4'd1, 1'b0, 4'd2, 16'({B, AR})};
    tests[1] = '{4'hf, 4'b1111, 4'd1, 1'b0, 4'd4, 16'({B, R, AW, AR})};
    tests[2] = '{4'hf, 4'b1111, 4'd1, 1'b1, 4'd4, 16'({B, R, AW, AR})};
    tests[3] = '{4'hf, 4'b0010, 4'd1, 1'b0, 4'd1, 16'(AW)};
    // the R burst wins first because the pointer rests on AW
    tests[4] = '{4'hf, 4'b1101, 4'd4, 1'b0, 4'd6, 16'({AR, B, R, R, R, R})};
    tests[5] = '{4'hf, 4'b1111, 4'd3, 1'b0, 4'd6, 16'({AR, B, R, R, R, AW})};
    tests[6] = '{4'b1101, 4'b1111, 4'd1, 1'b0, 4'd3, 16'({AR, B, R})};
    names    = '{"reset_contend", "pass_through", "round_robin", "second_round",
                 "burst_lock", "back_pressure", "channel_enable"};
    repeat (10) @(negedge clk);
    resetn = 1'b0;
    if (stream_tvalid !== 1'b0)
      report_error("stream_tvalid is high right after reset");
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("%0d tests run, %0d with errors, %0d errors in total",
             NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run timed out", NUM_TESTS * 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== axi_trace.f ====
+incdir+include
hdl/axi_chan_pkg.sv
hdl/trace_pkg.sv
hdl/channel_tap.sv
hdl/trace_arbiter.sv
hdl/trace_output_stage.sv
hdl/axi_trace_top.sv
bench/axi_trace_props.sv
bench/axi_trace_tb.sv

// ==== Bender.yml ====
package:
  name: axi_trace

sources:
  - include_dirs:
      - include
    files:
      - hdl/axi_chan_pkg.sv
      - hdl/trace_pkg.sv
      - hdl/channel_tap.sv
      - hdl/trace_arbiter.sv
      - hdl/trace_output_stage.sv
      - hdl/axi_trace_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/axi_trace_props.sv
      - bench/axi_trace_tb.sv
